// ==== flist.f ====
+incdir+verilog
verilog/npc_pkg.sv
verilog/fetch_unit.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/mem_writeback.sv
verilog/npc.sv
sim/npc_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = npc_tb
RTL_TOP    = npc
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/npc_tb.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module npc_tb;

    // standard rv32i major opcodes
    localparam logic [6:0] lui_opc    = 7'b0110111;
    localparam logic [6:0] auipc_opc  = 7'b0010111;
    localparam logic [6:0] jal_opc    = 7'b1101111;
    localparam logic [6:0] jalr_opc   = 7'b1100111;
    localparam logic [6:0] load_opc   = 7'b0000011;
    localparam logic [6:0] store_opc  = 7'b0100011;
    localparam logic [6:0] imm_opc    = 7'b0010011;
    localparam logic [6:0] reg_opc    = 7'b0110011;
    localparam logic [6:0] system_opc = 7'b1110011;

    logic clk = 1'b0;
    logic reset;
    logic prog_wen;
    logic [7:0] prog_addr;
    logic [31:0] prog_data;
    logic [31:0] pc;
    logic [31:0] alu_result;
    npc_pkg::retire_t retire;
    logic halted;

    // program image shared by loader and model
    logic [31:0] prog [0:`NPC_IMEM_WORDS-1];
    int prog_len;

    // software model state
    logic [31:0] model_pc;
    logic [31:0] model_regs [0:31];
    logic [31:0] model_dmem [0:`NPC_DMEM_WORDS-1];
    logic        model_halted;

    logic [31:0]      exp_pc;
    npc_pkg::retire_t exp_ret;
    logic             exp_halted;
    logic [31:0]      exp_alu;
    logic             exp_alu_known;

    int error_count;
    int check_count;
    int test_count;
    int post_halt;
    int run_cycles;
    int cycle_limit;
    string test_name;

    npc UUT (
        .clk        (clk),
        .reset      (reset),
        .prog_wen   (prog_wen),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc         (pc),
        .alu_result (alu_result),
        .retire     (retire),
        .halted     (halted)
    );

    always #50 clk = ~clk;

    // sign-extended 12-bit value
    function int random_imm12();
        logic [31:0] r;
        r = $urandom();
        return int'({{20{r[11]}}, r[11:0]});
    endfunction

    // 20-bit upper immediate field
    function int random_upper();
        logic [31:0] r;
        r = $urandom();
        return int'({12'd0, r[19:0]});
    endfunction

    task raw_word(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task i_insn(input logic [6:0] opc, input int f3, input int rd, input int rs1, input int imm);
        logic [31:0] f, d, s, m;
        f = f3;
        d = rd;
        s = rs1;
        m = imm;
        raw_word({m[11:0], s[4:0], f[2:0], d[4:0], opc});
    endtask

    task s_insn(input int f3, input int rs1, input int rs2, input int imm);
        logic [31:0] f, s, t, m;
        f = f3;
        s = rs1;
        t = rs2;
        m = imm;
        raw_word({m[11:5], t[4:0], s[4:0], f[2:0], m[4:0], store_opc});
    endtask

    task r_insn(input int f3, input int rd, input int rs1, input int rs2);
        logic [31:0] f, d, s, t;
        f = f3;
        d = rd;
        s = rs1;
        t = rs2;
        raw_word({7'd0, t[4:0], s[4:0], f[2:0], d[4:0], reg_opc});
    endtask

    task u_insn(input logic [6:0] opc, input int rd, input int upper);
        logic [31:0] d, m;
        d = rd;
        m = upper;
        raw_word({m[19:0], d[4:0], opc});
    endtask

    // jal with byte offset
    task j_insn(input int rd, input int offset);
        logic [31:0] d, m;
        d = rd;
        m = offset;
        raw_word({m[20], m[10:1], m[11], m[19:12], d[4:0], jal_opc});
    endtask

    // one cycle of the isa model, returns what the core should show now
    function void ref_step(
        output logic [31:0]      want_pc,
        output npc_pkg::retire_t want_ret,
        output logic             want_halted,
        output logic [31:0]      want_alu,
        output logic             want_alu_known
    );
        logic [31:0] ins;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] next_pc;
        logic        wen;
        logic [31:0] wdata;
        want_pc        = model_pc;
        want_halted    = model_halted;
        want_ret       = '0;
        want_alu       = 32'd0;
        want_alu_known = 1'b0;
        if (model_halted) begin
            return;
        end
        ins     = prog[model_pc[9:2]];
        rs1_val = model_regs[ins[19:15]];
        rs2_val = model_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_u   = {ins[31:12], 12'd0};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        addr    = rs1_val + ((ins[6:0] == store_opc) ? imm_s : imm_i);
        word    = model_dmem[addr[9:2]];
        next_pc = model_pc + 32'd4;
        wen     = 1'b0;
        wdata   = 32'd0;
        case (ins[6:0])
            lui_opc: begin
                wen   = 1'b1;
                wdata = imm_u;
            end
            auipc_opc: begin
                wen            = 1'b1;
                wdata          = model_pc + imm_u;
                want_alu       = model_pc + imm_u;
                want_alu_known = 1'b1;
            end
            jal_opc: begin
                wen     = 1'b1;
                wdata   = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            jalr_opc: begin
                if (ins[14:12] == 3'b000) begin
                    wen     = 1'b1;
                    wdata   = model_pc + 32'd4;
                    next_pc = (rs1_val + imm_i) & 32'hffff_fffe;
                end
            end
            load_opc: begin
                if (ins[14:12] == 3'b010) begin
                    wen            = 1'b1;
                    wdata          = word;
                    want_alu       = addr;
                    want_alu_known = 1'b1;
                end else if (ins[14:12] == 3'b100) begin
                    // lbu, addressed byte moved down then zero extended
                    wen            = 1'b1;
                    word           = word >> {addr[1:0], 3'b000};
                    wdata          = {24'd0, word[7:0]};
                    want_alu       = addr;
                    want_alu_known = 1'b1;
                end
            end
            store_opc: begin
                if (ins[14:12] == 3'b010) begin
                    model_dmem[addr[9:2]] = rs2_val;
                    want_alu              = addr;
                    want_alu_known        = 1'b1;
                end else if (ins[14:12] == 3'b000) begin
                    model_dmem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = rs2_val[7:0];
                    want_alu       = addr;
                    want_alu_known = 1'b1;
                end
            end
            imm_opc: begin
                if (ins[14:12] == 3'b000) begin
                    wen            = 1'b1;
                    wdata          = rs1_val + imm_i;
                    want_alu       = rs1_val + imm_i;
                    want_alu_known = 1'b1;
                end else if (ins[14:12] == 3'b011) begin
                    wen            = 1'b1;
                    wdata          = {31'd0, rs1_val < imm_i};
                    want_alu       = {31'd0, rs1_val < imm_i};
                    want_alu_known = 1'b1;
                end
            end
            reg_opc: begin
                if (ins[14:12] == 3'b000) begin
                    wen            = 1'b1;
                    wdata          = rs1_val + rs2_val;
                    want_alu       = rs1_val + rs2_val;
                    want_alu_known = 1'b1;
                end
            end
            system_opc: begin
                // ecall and friends fall through as no-ops
                if (ins == `NPC_EBREAK) begin
                    next_pc      = model_pc;
                    model_halted = 1'b1;
                end
            end
            default: begin
                // anything else, pc + 4 only
            end
        endcase
        want_ret.valid   = 1'b1;
        want_ret.rd_wen  = wen;
        want_ret.rd      = ins[11:7];
        want_ret.rd_data = wdata;
        if (wen && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = wdata;
        end
        model_pc = next_pc;
    endfunction

    task compare_value(input string name, input logic [31:0] got, input logic [31:0] want);
        check_count++;
        assert (got === want) else begin
            $display("Error: %s expected %h got %h (pc %h)", name, want, got, exp_pc);
            error_count++;
        end
    endtask

    // model tracks the core, compared mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            model_pc     = `NPC_RESET_PC;
            model_halted = 1'b0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'd0;
            end
            post_halt  = 0;
            run_cycles = 0;
        end else begin
            ref_step(exp_pc, exp_ret, exp_halted, exp_alu, exp_alu_known);
            compare_value("pc", pc, exp_pc);
            compare_value("halted", {31'd0, halted}, {31'd0, exp_halted});
            compare_value("retire.valid", {31'd0, retire.valid}, {31'd0, exp_ret.valid});
            compare_value("retire.rd_wen", {31'd0, retire.rd_wen}, {31'd0, exp_ret.rd_wen});
            // rd fields only mean something with a write
            if (exp_ret.rd_wen) begin
                compare_value("retire.rd", {27'd0, retire.rd}, {27'd0, exp_ret.rd});
                compare_value("retire.rd_data", retire.rd_data, exp_ret.rd_data);
            end
            // alu output defined for arithmetic and memory addresses only
            if (exp_alu_known) begin
                compare_value("alu_result", alu_result, exp_alu);
            end
            if (exp_halted) begin
                post_halt++;
            end
            run_cycles++;
        end
    end

    // per-test cycle budget from program length
    initial begin : watchdog
        wait (run_cycles > cycle_limit);
        $display("timeout in test %s, program never halted", test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    // load under reset, release, wait for halt plus 10 idle cycles
    task run_program(input string name);
        int load_cycles;
        int errors_before;
        load_cycles   = (prog_len > 5) ? prog_len : 5;
        errors_before = error_count;
        test_name     = name;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < load_cycles; i++) begin
            prog_wen  <= (i < prog_len);
            prog_addr <= 8'(i);
            prog_data <= prog[i];
            @(posedge clk);
        end
        prog_wen    <= 1'b0;
        reset       <= 1'b0;
        cycle_limit = prog_len + 20;
        wait (post_halt >= 10);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - errors_before);
    endtask

    task arith_program();
        prog_len = 0;
        i_insn(imm_opc, 0, 1, 0, random_imm12());
        i_insn(imm_opc, 0, 2, 0, random_imm12());
        r_insn(0, 3, 1, 2);
        i_insn(imm_opc, 0, 4, 3, random_imm12());
        i_insn(imm_opc, 0, 6, 0, 100);
        // sltiu above, equal, below, all ones
        i_insn(imm_opc, 3, 7, 6, 101);
        i_insn(imm_opc, 3, 8, 6, 100);
        i_insn(imm_opc, 3, 9, 6, 50);
        i_insn(imm_opc, 3, 10, 6, -1);
        i_insn(imm_opc, 3, 11, 1, random_imm12());
        u_insn(lui_opc, 12, random_upper());
        u_insn(auipc_opc, 13, random_upper());
        r_insn(0, 14, 12, 13);
        raw_word(`NPC_EBREAK);
    endtask

    task jump_program();
        prog_len = 0;
        i_insn(imm_opc, 0, 1, 0, 5);
        // jal over two words
        j_insn(2, 12);
        i_insn(imm_opc, 0, 1, 0, 99);
        i_insn(imm_opc, 0, 1, 0, 98);
        u_insn(auipc_opc, 3, 0);
        // odd target, lsb dropped lands on word 8
        i_insn(imm_opc, 0, 3, 3, 17);
        i_insn(jalr_opc, 0, 4, 3, 0);
        i_insn(imm_opc, 0, 1, 0, 97);
        r_insn(0, 5, 2, 4);
        raw_word(`NPC_EBREAK);
    endtask

    task word_program();
        int off [4];
        prog_len = 0;
        i_insn(imm_opc, 0, 1, 0, 256);
        for (int k = 0; k < 4; k++) begin
            off[k] = int'($urandom() % 32) * 4;
            u_insn(lui_opc, 2 + k, random_upper());
            i_insn(imm_opc, 0, 2 + k, 2 + k, random_imm12());
            s_insn(2, 1, 2 + k, off[k]);
        end
        for (int k = 0; k < 4; k++) begin
            i_insn(load_opc, 2, 6 + k, 1, off[k]);
        end
        raw_word(`NPC_EBREAK);
    endtask

    task byte_program();
        prog_len = 0;
        i_insn(imm_opc, 0, 1, 0, 512);
        u_insn(lui_opc, 2, random_upper());
        i_insn(imm_opc, 0, 2, 2, random_imm12());
        s_insn(2, 1, 2, 0);
        // one lane at a time, whole word read back after each
        for (int k = 0; k < 4; k++) begin
            i_insn(imm_opc, 0, 3, 0, random_imm12());
            s_insn(0, 1, 3, k);
            i_insn(load_opc, 2, 4, 1, 0);
        end
        for (int k = 0; k < 4; k++) begin
            i_insn(load_opc, 4, 5 + k, 1, k);
        end
        raw_word(`NPC_EBREAK);
    endtask

    task zero_reg_program();
        prog_len = 0;
        i_insn(imm_opc, 0, 0, 0, random_imm12());
        u_insn(lui_opc, 0, random_upper());
        r_insn(0, 1, 0, 0);
        i_insn(imm_opc, 0, 2, 0, 0);
        // xori, zero word, ecall, all ones
        i_insn(imm_opc, 4, 3, 1, 7);
        raw_word(32'h0000_0000);
        raw_word(32'h0000_0073);
        raw_word(32'hffff_ffff);
        i_insn(imm_opc, 0, 5, 0, 1);
        raw_word(`NPC_EBREAK);
    endtask

    task halt_program();
        prog_len = 0;
        i_insn(imm_opc, 0, 1, 0, random_imm12());
        raw_word(`NPC_EBREAK);
        i_insn(imm_opc, 0, 1, 0, 1);
        i_insn(imm_opc, 0, 2, 0, 2);
    endtask

    initial begin : main_seq
        reset     <= 1'b1;
        prog_wen  <= 1'b0;
        prog_addr <= 8'd0;
        prog_data <= 32'd0;
        void'($urandom(32'ha4bf));
        arith_program();
        run_program("arithmetic");
        jump_program();
        run_program("jumps");
        word_program();
        run_program("word_access");
        byte_program();
        run_program("byte_access");
        zero_reg_program();
        run_program("x0_and_noop");
        halt_program();
        run_program("halt");
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/npc.sv ====
`timescale 1ns/1ps

module npc (
    input  logic             clk,
    input  logic             reset,
    input  logic             prog_wen,
    input  logic [7:0]       prog_addr,
    input  logic [31:0]      prog_data,
    output logic [31:0]      pc,
    output logic [31:0]      alu_result,
    output npc_pkg::retire_t retire,
    output logic             halted
);

    logic [31:0]    inst;
    npc_pkg::ctrl_t ctrl;
    logic [31:0]    src1;
    logic [31:0]    src2;
    logic           wb_wen;
    logic [4:0]     wb_addr;
    logic [31:0]    wb_data;

    // pc, halt and instruction memory
    fetch_unit u_fetch (
        .clk       (clk),
        .reset     (reset),
        .prog_wen  (prog_wen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .ctrl      (ctrl),
        .src1      (src1),
        .pc        (pc),
        .inst      (inst),
        .halted    (halted)
    );

    inst_decode u_decode (
        .inst (inst),
        .ctrl (ctrl)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .wen    (wb_wen),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (src1),
        .rdata2 (src2)
    );

    alu u_alu (
        .pc     (pc),
        .src1   (src1),
        .src2   (src2),
        .ctrl   (ctrl),
        .result (alu_result)
    );

    // rs2 is the store data
    mem_writeback u_memwb (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_result (alu_result),
        .store_data (src2),
        .halted     (halted),
        .wb_wen     (wb_wen),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .retire     (retire)
    );

endmodule

// ==== verilog/mem_writeback.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module mem_writeback (
    input  logic             clk,
    input  logic             reset,
    input  npc_pkg::ctrl_t   ctrl,
    input  logic [31:0]      pc,
    input  logic [31:0]      alu_result,
    input  logic [31:0]      store_data,
    input  logic             halted,
    output logic             wb_wen,
    output logic [4:0]       wb_addr,
    output logic [31:0]      wb_data,
    output npc_pkg::retire_t retire
);

    logic [31:0] dmem [0:`NPC_DMEM_WORDS-1];
    logic [7:0]  word_idx;
    logic [1:0]  lane;
    logic [31:0] mem_word;
    logic [7:0]  mem_byte_val;
    logic [31:0] load_data;
    logic        active;
    logic        store_en;

    // alu result doubles as the effective address
    assign word_idx = alu_result[9:2];
    assign lane     = alu_result[1:0];

    // nothing commits in reset or after ebreak
    assign active   = !reset && !halted;
    assign store_en = active && ctrl.mem_wen;

    always_ff @(posedge clk) begin
        if (store_en) begin
            if (ctrl.mem_byte) begin
                // sb touches a single lane
                dmem[word_idx][{lane, 3'b000} +: 8] <= store_data[7:0];
            end else begin
                dmem[word_idx] <= store_data;
            end
        end
    end

    // combinational load path
    assign mem_word     = dmem[word_idx];
    assign mem_byte_val = mem_word[{lane, 3'b000} +: 8];

    always_comb begin
        if (!ctrl.mem_ren) begin
            load_data = 32'd0;
        end else if (ctrl.mem_byte) begin
            // lbu zero extends
            load_data = {24'd0, mem_byte_val};
        end else begin
            load_data = mem_word;
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            npc_pkg::wb_mem: wb_data = load_data;
            npc_pkg::wb_pc4: wb_data = pc + 32'd4;
            npc_pkg::wb_imm: wb_data = ctrl.imm;
            default:         wb_data = alu_result;
        endcase
    end

    // x0 still reports a write, reg file drops it
    assign wb_wen  = active && ctrl.reg_wen;
    assign wb_addr = ctrl.rd;

    assign retire.valid   = active;
    assign retire.rd_wen  = wb_wen;
    assign retire.rd      = ctrl.rd;
    assign retire.rd_data = wb_data;

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]    pc,
    input  logic [31:0]    src1,
    input  logic [31:0]    src2,
    input  npc_pkg::ctrl_t ctrl,
    output logic [31:0]    result
);

    logic [31:0] op_a;
    logic [31:0] op_b;

    // auipc takes pc, immediate forms take imm
    assign op_a = ctrl.src1_is_pc ? pc : src1;
    assign op_b = ctrl.src2_is_imm ? ctrl.imm : src2;

    always_comb begin
        case (ctrl.alu_op)
            npc_pkg::alu_sltu: result = (op_a < op_b) ? 32'd1 : 32'd0;
            default:           result = op_a + op_b;
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            // x0 writes silently dropped
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module inst_decode (
    input  logic [31:0]    inst,
    output npc_pkg::ctrl_t ctrl
);

    npc_pkg::opcode_e opcode;
    logic [2:0]  funct3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = npc_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    // sign-extended immediate formats
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // everything inactive unless recognised below
        ctrl        = '0;
        ctrl.alu_op = npc_pkg::alu_add;
        ctrl.wb_sel = npc_pkg::wb_alu;
        // register fields are harmless when enables stay low
        ctrl.rd     = inst[11:7];
        ctrl.rs1    = inst[19:15];
        ctrl.rs2    = inst[24:20];

        case (opcode)
            npc_pkg::op_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm     = imm_u;
                ctrl.wb_sel  = npc_pkg::wb_imm;
            end
            npc_pkg::op_auipc: begin
                // pc + upper immediate through the alu
                ctrl.reg_wen     = 1'b1;
                ctrl.imm         = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
            end
            npc_pkg::op_jal: begin
                ctrl.reg_wen = 1'b1;
                ctrl.imm     = imm_j;
                ctrl.wb_sel  = npc_pkg::wb_pc4;
                ctrl.is_jal  = 1'b1;
            end
            npc_pkg::op_jalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.reg_wen = 1'b1;
                    ctrl.imm     = imm_i;
                    ctrl.wb_sel  = npc_pkg::wb_pc4;
                    ctrl.is_jalr = 1'b1;
                end
            end
            npc_pkg::op_load: begin
                // lw = 010, lbu = 100
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.imm         = imm_i;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.mem_ren     = 1'b1;
                    ctrl.mem_byte    = (funct3 == 3'b100);
                    ctrl.wb_sel      = npc_pkg::wb_mem;
                end
            end
            npc_pkg::op_store: begin
                // sw = 010, sb = 000
                if (funct3 == 3'b010 || funct3 == 3'b000) begin
                    ctrl.imm         = imm_s;
                    ctrl.src2_is_imm = 1'b1;
                    ctrl.mem_wen     = 1'b1;
                    ctrl.mem_byte    = (funct3 == 3'b000);
                end
            end
            npc_pkg::op_imm: begin
                // addi = 000, sltiu = 011
                if (funct3 == 3'b000 || funct3 == 3'b011) begin
                    ctrl.reg_wen     = 1'b1;
                    ctrl.imm         = imm_i;
                    ctrl.src2_is_imm = 1'b1;
                    if (funct3 == 3'b011) begin
                        ctrl.alu_op = npc_pkg::alu_sltu;
                    end
                end
            end
            npc_pkg::op_reg: begin
                // add only
                if (funct3 == 3'b000) begin
                    ctrl.reg_wen = 1'b1;
                end
            end
            npc_pkg::op_system: begin
                // only the exact ebreak word counts
                ctrl.is_ebreak = (inst == `NPC_EBREAK);
            end
            default: begin
                // unknown opcode retires as a no-op
            end
        endcase
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"

module fetch_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           prog_wen,
    input  logic [7:0]     prog_addr,
    input  logic [31:0]    prog_data,
    input  npc_pkg::ctrl_t ctrl,
    input  logic [31:0]    src1,
    output logic [31:0]    pc,
    output logic [31:0]    inst,
    output logic           halted
);

    logic [31:0] imem [0:`NPC_IMEM_WORDS-1];
    logic [31:0] next_pc;
    logic [31:0] jalr_target;
    npc_pkg::fetch_state_e state;

    // program load only while the core sits in reset
    always_ff @(posedge clk) begin
        if (reset && prog_wen) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // word fetch, byte offset bits dropped
    assign inst = imem[pc[9:2]];

    assign jalr_target = src1 + ctrl.imm;

    // priority: hold, jalr, jal, sequential
    always_comb begin
        if (state == npc_pkg::st_halted || ctrl.is_ebreak) begin
            next_pc = pc;
        end else if (ctrl.is_jalr) begin
            // target lsb always cleared
            next_pc = {jalr_target[31:1], 1'b0};
        end else if (ctrl.is_jal) begin
            next_pc = pc + ctrl.imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= `NPC_RESET_PC;
            state <= npc_pkg::st_run;
        end else begin
            pc <= next_pc;
            // ebreak retires once, then the core parks
            if (state == npc_pkg::st_run && ctrl.is_ebreak) begin
                state <= npc_pkg::st_halted;
            end
        end
    end

    assign halted = (state == npc_pkg::st_halted);

endmodule

// ==== verilog/npc_pkg.sv ====
package npc_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic {
        alu_add  = 1'b0,
        alu_sltu = 1'b1
    } alu_op_e;

    // where rd data comes from
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2,
        wb_imm = 2'd3
    } wb_sel_e;

    typedef enum logic {
        st_run    = 1'b0,
        st_halted = 1'b1
    } fetch_state_e;

    // decoded control for one instruction
    typedef struct packed {
        logic        reg_wen;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        src1_is_pc;
        logic        src2_is_imm;
        alu_op_e     alu_op;
        logic        mem_ren;
        logic        mem_wen;
        // byte access instead of word (lbu, sb)
        logic        mem_byte;
        wb_sel_e     wb_sel;
        logic        is_jal;
        logic        is_jalr;
        logic        is_ebreak;
    } ctrl_t;

    // what retired this cycle
    typedef struct packed {
        logic        valid;
        logic        rd_wen;
        logic [4:0]  rd;
        logic [31:0] rd_data;
    } retire_t;

endpackage

// ==== verilog/npc_defines.svh ====
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

// first fetch address after reset
`define NPC_RESET_PC 32'h8000_0000

// instruction memory depth in words
// word index comes from pc[9:2]
`define NPC_IMEM_WORDS 256

// data memory depth in words
// word index comes from addr[9:2], upper bits ignored
`define NPC_DMEM_WORDS 256

// full ebreak encoding
`define NPC_EBREAK 32'h0010_0073

`endif
